// ==== verilog.f ====
hdl/mem_pkg.sv
hdl/line_cache.sv
hdl/mem_arbiter.sv
hdl/cacheline_adaptor.sv
hdl/mem_hier.sv
tests/burst_mem_model.sv
tests/mem_hier_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mem_hier_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/mem_hier_tb.sv ====
`default_nettype none

module mem_hier_tb
import mem_pkg::*;
();

    localparam int TIMEOUT = 200;       // cycles per wait

    logic       clk;
    logic       rst;
    cpu_req_t   imem_req;
    cpu_rsp_t   imem_rsp;
    cpu_req_t   dmem_req;
    cpu_rsp_t   dmem_rsp;
    bmem_req_t  bmem_req;
    bmem_rsp_t  bmem_rsp;
    logic       wr_start;
    bmem_req_t  wr_req;

    logic [31:0] shadow [logic [31:0]]; // words written by the test
    bmem_req_t   wb_log [$];            // burst writes seen by memory
    int          seed = 36;
    int          ireq_cnt = 0;
    int          dreq_cnt = 0;
    int          irsp_cnt = 0;
    int          drsp_cnt = 0;
    int          ilat = 0;              // cycles to the last imem resp
    int          dlat = 0;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    mem_hier i_mem_hier (
        .clk        (clk),
        .rst        (rst),
        .imem_req_i (imem_req),
        .imem_rsp_o (imem_rsp),
        .dmem_req_i (dmem_req),
        .dmem_rsp_o (dmem_rsp),
        .bmem_req_o (bmem_req),
        .bmem_rsp_i (bmem_rsp)
    );

    burst_mem_model i_burst_mem_model (
        .clk        (clk),
        .rst        (rst),
        .bmem_req_i (bmem_req),
        .bmem_rsp_o (bmem_rsp),
        .wr_start_o (wr_start),
        .wr_req_o   (wr_req)
    );

    always @(posedge clk) begin
        if (wr_start) begin
            wb_log.push_back(wr_req);
        end
    end

    // resp pulses per port, compared with issued requests
    always @(negedge clk) begin
        if (imem_rsp.resp) begin
            irsp_cnt++;
        end
        if (dmem_rsp.resp) begin
            drsp_cnt++;
        end
    end

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return init_word(addr);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  mask);
        logic [31:0] lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_word & ~lanes) | (wdata & lanes);
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input string name, input logic [31:0] expected,
                             input cpu_rsp_t actual);
        if (actual.rdata !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual.rdata);
            abort_run();
        end
    endtask

    task automatic check_wb_addr(input string name, input logic [31:0] expected,
                                 input bmem_req_t actual);
        if (actual.addr !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual.addr);
            abort_run();
        end
    endtask

    task automatic check_resp_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // a hit answers in the cycle after the request is sampled
    task automatic verify_hit_latency(input string name, input int actual);
        if (actual != 1) begin
            $display("FAILED %s: expected %0d, actual %0d", name, 1, actual);
            abort_run();
        end
    endtask

    task automatic imem_read(input logic [31:0] addr, output cpu_rsp_t rsp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        imem_req       = '0;
        imem_req.addr  = addr;
        imem_req.read  = 1'b1;
        ireq_cnt++;
        do begin
            @(negedge clk);
            cycles++;
        end while (!imem_rsp.resp && cycles < TIMEOUT);
        if (!imem_rsp.resp) begin
            $display("instruction port stalled, no resp for address %h", addr);
            abort_run();
        end
        rsp  = imem_rsp;
        ilat = cycles;
        @(negedge clk);
        imem_req = '0;              // drop in the cycle after resp
    endtask

    task automatic dmem_access(input logic [31:0] addr, input logic wr, input logic [3:0] mask,
                               input logic [31:0] wdata, output cpu_rsp_t rsp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        dmem_req.addr  = addr;
        dmem_req.read  = !wr;
        dmem_req.write = wr;
        dmem_req.wmask = mask;
        dmem_req.wdata = wdata;
        dreq_cnt++;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dmem_rsp.resp && cycles < TIMEOUT);
        if (!dmem_rsp.resp) begin
            $display("data port stalled, no resp for address %h", addr);
            abort_run();
        end
        rsp  = dmem_rsp;
        dlat = cycles;
        @(negedge clk);
        dmem_req = '0;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] wdata);
        cpu_rsp_t rsp;
        dmem_access(addr, 1'b1, mask, wdata, rsp);
        shadow[addr] = merge_bytes(expect_word(addr), wdata, mask);
    endtask

    task automatic data_read_check(input string name, input logic [31:0] addr);
        cpu_rsp_t rsp;
        dmem_access(addr, 1'b0, 4'b0000, 32'h0, rsp);
        check_rsp(name, expect_word(addr), rsp);
    endtask

    task automatic inst_read_check(input string name, input logic [31:0] addr);
        cpu_rsp_t rsp;
        imem_read(addr, rsp);
        check_rsp(name, expect_word(addr), rsp);
    endtask

    initial begin
        cpu_rsp_t    irsp;
        cpu_rsp_t    drsp;
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] last_wr;
        int          op;

        rst      = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        last_wr  = 32'h0000_0040;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (imem_rsp.resp || dmem_rsp.resp || bmem_req.read || bmem_req.write) begin
                $display("resp or burst request active right after reset, cycle %0d", i);
                abort_run();
            end
        end

        inst_read_check("cold imem read", 32'h0000_4100);
        inst_read_check("imem hit", 32'h0000_4100);
        verify_hit_latency("imem hit latency", ilat);
        inst_read_check("imem hit other word", 32'h0000_411C);
        verify_hit_latency("imem hit other word latency", ilat);
        data_read_check("cold dmem read", 32'h0000_0104);
        data_read_check("dmem hit", 32'h0000_0104);
        verify_hit_latency("dmem hit latency", dlat);

        // byte-mask merges in the line at index 2
        data_write(32'h0000_0040, 4'b0011, 32'hDEAD_BEEF);
        data_write(32'h0000_0044, 4'b1100, 32'hCAFE_F00D);
        data_write(32'h0000_0048, 4'b1010, 32'h1234_5678);
        data_write(32'h0000_004C, 4'b0001, 32'h0000_0099);
        data_write(32'h0000_0040, 4'b1000, 32'h7700_0000);
        data_read_check("merge word 0", 32'h0000_0040);
        data_read_check("merge word 1", 32'h0000_0044);
        data_read_check("merge word 2", 32'h0000_0048);
        data_read_check("merge word 3", 32'h0000_004C);

        // same index, tag 0 then tag 1
        wb_log.delete();
        data_write(32'h0000_0064, 4'b1111, 32'hA5C3_0F96);
        data_read_check("conflicting read", 32'h0000_0264);
        if (wb_log.size() == 0) begin
            $display("no burst write recorded for the evicted dirty line");
            abort_run();
        end
        check_resp_count("write-back count", 1, wb_log.size());
        check_wb_addr("victim address", 32'h0000_0060, wb_log[0]);
        data_read_check("reread after eviction", 32'h0000_0064);

        // both ports miss in the same cycle
        fork
            imem_read(32'h0000_4020, irsp);
            dmem_access(32'h0000_0324, 1'b0, 4'b0000, 32'h0, drsp);
        join
        check_rsp("dual miss imem", expect_word(32'h0000_4020), irsp);
        check_rsp("dual miss dmem", expect_word(32'h0000_0324), drsp);
        @(posedge clk);
        check_resp_count("imem resp count", ireq_cnt, irsp_cnt);
        check_resp_count("dmem resp count", dreq_cnt, drsp_cnt);

        for (int n = 0; n < 300; n++) begin
            op   = $unsigned($random(seed)) % 4;
            addr = $random(seed) & 32'h0000_07FC;   // 2 KB, four tags per set
            rnd  = $random(seed);
            case (op)
                0: inst_read_check($sformatf("random op %0d imem read", n), 32'h0000_4000 | addr);
                1: data_read_check($sformatf("random op %0d dmem read", n), addr);
                2: begin
                    data_write(addr, rnd[3:0], $random(seed));
                    last_wr = addr;
                end
                default: data_read_check($sformatf("random op %0d reread", n), last_wr);
            endcase
        end

        @(posedge clk);
        check_resp_count("imem resp total", ireq_cnt, irsp_cnt);
        check_resp_count("dmem resp total", dreq_cnt, drsp_cnt);
        $display("all tests passed");
        $finish;
    end

endmodule : mem_hier_tb

`default_nettype wire

// ==== tests/burst_mem_model.sv ====
`default_nettype none

module burst_mem_model
import mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  bmem_req_t   bmem_req_i,
    output bmem_rsp_t   bmem_rsp_o,
    output logic        wr_start_o,     // a burst write has begun
    output bmem_req_t   wr_req_o
);

    logic [31:0] words [logic [31:0]];  // sparse, keyed by word address
    logic [31:0] base;
    int          seed = 36;
    int          delay;
    int          beat;
    logic        busy;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] load_word(input logic [31:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return fill_word(addr);
    endfunction

    initial begin
        bmem_rsp_o = '0;
        wr_start_o = 1'b0;
        wr_req_o   = '0;
        busy       = 1'b0;
        delay      = 0;
        beat       = 0;
    end

    always @(negedge clk) begin
        if (rst) begin
            bmem_rsp_o = '0;
            wr_start_o = 1'b0;
            busy       = 1'b0;
        end else begin
            bmem_rsp_o.resp = 1'b0;
            wr_start_o      = 1'b0;
            if (!busy) begin
                if (bmem_req_i.read || bmem_req_i.write) begin
                    busy  = 1'b1;
                    beat  = 0;
                    delay = 1 + ($unsigned($random(seed)) % 4);  // 1 to 4 cycles
                    if (bmem_req_i.write) begin
                        wr_start_o = 1'b1;
                        wr_req_o   = bmem_req_i;
                    end
                end
            end else if (delay > 1) begin
                delay = delay - 1;
            end else begin
                base = bmem_req_i.addr + beat * 8;
                if (bmem_req_i.write) begin
                    words[base]     = bmem_req_i.wdata[31:0];
                    words[base + 4] = bmem_req_i.wdata[63:32];
                end else begin
                    bmem_rsp_o.rdata = {load_word(base + 4), load_word(base)};
                end
                bmem_rsp_o.resp = 1'b1;
                beat  = beat + 1;
                delay = 1 + ($unsigned($random(seed)) % 3);  // gap before next beat
                if (beat == BEATS) begin
                    busy = 1'b0;
                end
            end
        end
    end

endmodule : burst_mem_model

`default_nettype wire

// ==== hdl/mem_hier.sv ====
`default_nettype none

module mem_hier
import mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  cpu_req_t    imem_req_i,
    output cpu_rsp_t    imem_rsp_o,
    input  cpu_req_t    dmem_req_i,
    output cpu_rsp_t    dmem_rsp_o,
    output bmem_req_t   bmem_req_o,
    input  bmem_rsp_t   bmem_rsp_i
);

    line_req_t  iline_req;      // icache -> arbiter
    line_rsp_t  iline_rsp;
    line_req_t  dline_req;      // dcache -> arbiter
    line_rsp_t  dline_rsp;
    line_req_t  pline_req;      // arbiter -> adaptor
    line_rsp_t  pline_rsp;

    line_cache #(.WRITABLE(1'b0)) i_imem_cache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (imem_req_i),
        .cpu_rsp_o  (imem_rsp_o),
        .line_req_o (iline_req),
        .line_rsp_i (iline_rsp)
    );

    line_cache #(.WRITABLE(1'b1)) i_dmem_cache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (dmem_req_i),
        .cpu_rsp_o  (dmem_rsp_o),
        .line_req_o (dline_req),
        .line_rsp_i (dline_rsp)
    );

    mem_arbiter i_mem_arbiter (
        .clk    (clk),
        .rst    (rst),
        .ireq_i (iline_req),
        .irsp_o (iline_rsp),
        .dreq_i (dline_req),
        .drsp_o (dline_rsp),
        .req_o  (pline_req),
        .rsp_i  (pline_rsp)
    );

    cacheline_adaptor i_cacheline_adaptor (
        .clk        (clk),
        .rst        (rst),
        .line_req_i (pline_req),
        .line_rsp_o (pline_rsp),
        .bmem_req_o (bmem_req_o),   // to burst memory
        .bmem_rsp_i (bmem_rsp_i)
    );

endmodule : mem_hier

`default_nettype wire

// ==== hdl/cacheline_adaptor.sv ====
`default_nettype none

module cacheline_adaptor
import mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  line_req_t   line_req_i,
    output line_rsp_t   line_rsp_o,
    output bmem_req_t   bmem_req_o,
    input  bmem_rsp_t   bmem_rsp_i
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_BUSY,     // bursts in flight
        A_DONE      // line resp cycle
    } adp_state_t;

    adp_state_t                 state_q;
    logic [$clog2(BEATS):0]     beat_cnt;   // one spare bit for the range check
    logic                       rd_q;
    logic                       wr_q;
    logic [WORD_BITS-1:0]       addr_q;
    logic [LINE_BITS-1:0]       line_q;
    logic                       start;
    logic                       last_beat;

    assign start     = (state_q == A_IDLE) && (line_req_i.read || line_req_i.write);
    assign last_beat = (state_q == A_BUSY) && bmem_rsp_i.resp && (beat_cnt == BEATS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= A_IDLE;
            beat_cnt <= '0;
            rd_q     <= 1'b0;
            wr_q     <= 1'b0;
        end else begin
            case (state_q)
                A_IDLE: begin
                    if (start) begin
                        rd_q     <= line_req_i.read;
                        wr_q     <= line_req_i.write;
                        beat_cnt <= '0;
                        state_q  <= A_BUSY;
                    end
                end
                A_BUSY: begin
                    if (last_beat) begin
                        rd_q     <= 1'b0;   // drop the cycle after beat 3
                        wr_q     <= 1'b0;
                        beat_cnt <= '0;
                        state_q  <= A_DONE;
                    end else if (bmem_rsp_i.resp) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: begin
                    state_q <= A_IDLE;
                end
            endcase
        end
    end

    // write: low beat goes out first; read: beats shift in from the top
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= line_req_i.addr;
            if (line_req_i.write) begin
                line_q <= line_req_i.wdata;
            end
        end else if ((state_q == A_BUSY) && bmem_rsp_i.resp) begin
            line_q <= {bmem_rsp_i.rdata, line_q[LINE_BITS-1:BURST_BITS]};
        end
    end

    assign bmem_req_o.addr  = addr_q;
    assign bmem_req_o.read  = rd_q;
    assign bmem_req_o.write = wr_q;
    assign bmem_req_o.wdata = line_q[BURST_BITS-1:0];

    assign line_rsp_o.rdata = line_q;   // held until next transfer
    assign line_rsp_o.resp  = (state_q == A_DONE);

    a_beat_range: assert property (@(posedge clk) disable iff (rst)
        beat_cnt < BEATS)
        else $error("beat counter past last beat");

endmodule : cacheline_adaptor

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter
import mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  line_req_t   ireq_i,
    output line_rsp_t   irsp_o,
    input  line_req_t   dreq_i,
    output line_rsp_t   drsp_o,
    output line_req_t   req_o,
    input  line_rsp_t   rsp_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GNT_I,
        ARB_GNT_D
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       ireq_active;
    logic       dreq_active;

    assign ireq_active = ireq_i.read | ireq_i.write;
    assign dreq_active = dreq_i.read | dreq_i.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (dreq_active) begin
                    state_d = ARB_GNT_D;    // data side wins ties
                end else if (ireq_active) begin
                    state_d = ARB_GNT_I;
                end
            end
            ARB_GNT_I, ARB_GNT_D: begin
                if (rsp_i.resp) begin
                    state_d = ARB_IDLE;     // free after the resp cycle
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        case (state_q)
            ARB_GNT_I: req_o = ireq_i;
            ARB_GNT_D: req_o = dreq_i;
            default:   req_o = '0;      // nothing while idle
        endcase
    end

    // line data goes to both, resp only to the granted side
    assign irsp_o.rdata = rsp_i.rdata;
    assign irsp_o.resp  = rsp_i.resp && (state_q == ARB_GNT_I);
    assign drsp_o.rdata = rsp_i.rdata;
    assign drsp_o.resp  = rsp_i.resp && (state_q == ARB_GNT_D);

    // every line resp reaches exactly one cache
    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        rsp_i.resp |-> (irsp_o.resp ^ drsp_o.resp))
        else $error("line resp not routed to exactly one cache");

endmodule : mem_arbiter

`default_nettype wire

// ==== hdl/line_cache.sv ====
`default_nettype none

module line_cache
import mem_pkg::*;
#(
    parameter bit WRITABLE = 1'b1
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  cpu_req_t        cpu_req_i,
    output cpu_rsp_t        cpu_rsp_o,
    output line_req_t       line_req_o,
    input  line_rsp_t       line_rsp_i
);

    typedef enum logic [1:0] {
        S_IDLE,     // compare tags
        S_WB,       // victim write back
        S_FETCH,
        S_RESP
    } state_t;

    state_t state_q;

    logic [TAG_BITS-1:0]    tag_arr  [SETS];
    logic [LINE_BITS-1:0]   line_arr [SETS];
    logic [SETS-1:0]        valid_q;

    logic [TAG_BITS-1:0]    req_tag;
    logic [INDEX_BITS-1:0]  req_idx;
    logic [OFFSET_BITS-3:0] req_word;   // word within line
    logic                   active;
    logic                   hit;
    logic                   victim_dirty;
    logic                   wr_hit;
    logic                   fill;
    logic [LINE_BITS-1:0]   merged_line;
    logic [WORD_BITS-1:0]   rdata_q;

    assign req_tag  = cpu_req_i.addr[WORD_BITS-1 -: TAG_BITS];
    assign req_idx  = cpu_req_i.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_word = cpu_req_i.addr[OFFSET_BITS-1:2];
    assign active   = cpu_req_i.read | cpu_req_i.write;
    assign hit      = valid_q[req_idx] && (tag_arr[req_idx] == req_tag);

    assign wr_hit = (state_q == S_IDLE) && hit && cpu_req_i.write && WRITABLE;
    assign fill   = (state_q == S_FETCH) && line_rsp_i.resp;

    // only the data side keeps dirty bits
    if (WRITABLE) begin : g_dirty
        logic [SETS-1:0] dirty_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                dirty_q <= '0;
            end else if (fill) begin
                dirty_q[req_idx] <= 1'b0;   // fresh line from memory
            end else if (wr_hit) begin
                dirty_q[req_idx] <= 1'b1;
            end
        end

        assign victim_dirty = valid_q[req_idx] & dirty_q[req_idx];
    end else begin : g_clean
        assign victim_dirty = 1'b0;
    end

    // byte-mask merge of the store word into its line
    always_comb begin
        merged_line = line_arr[req_idx];
        for (int b = 0; b < 4; b++) begin
            if (cpu_req_i.wmask[b]) begin
                merged_line[req_word*WORD_BITS + b*8 +: 8] = cpu_req_i.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (active) begin
                        if (hit) begin
                            state_q <= S_RESP;
                        end else if (victim_dirty) begin
                            state_q <= S_WB;
                        end else begin
                            state_q <= S_FETCH;
                        end
                    end
                end
                S_WB: begin
                    if (line_rsp_i.resp) begin
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (line_rsp_i.resp) begin
                        valid_q[req_idx] <= 1'b1;
                        state_q <= S_IDLE;  // retry as hit
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line_arr[req_idx] <= line_rsp_i.rdata;
            tag_arr[req_idx]  <= req_tag;
        end else if (wr_hit) begin
            line_arr[req_idx] <= merged_line;
        end
        if (state_q == S_IDLE) begin
            rdata_q <= line_arr[req_idx][req_word*WORD_BITS +: WORD_BITS];
        end
    end

    assign cpu_rsp_o.rdata = rdata_q;
    assign cpu_rsp_o.resp  = (state_q == S_RESP);

    always_comb begin
        line_req_o.read  = (state_q == S_FETCH);
        line_req_o.write = (state_q == S_WB);
        line_req_o.wdata = line_arr[req_idx];
        if (state_q == S_WB) begin
            // victim address from stored tag
            line_req_o.addr = {tag_arr[req_idx], req_idx, {OFFSET_BITS{1'b0}}};
        end else begin
            line_req_o.addr = {req_tag, req_idx, {OFFSET_BITS{1'b0}}};
        end
    end

    a_no_write_ro: assert property (@(posedge clk) disable iff (rst)
        WRITABLE || !cpu_req_i.write)
        else $error("write request on read-only cache");

    // core holds its request until resp
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (active && !cpu_rsp_o.resp) |=> $stable(cpu_req_i))
        else $error("request changed while waiting");

endmodule : line_cache

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int WORD_BITS   = 32;
    localparam int LINE_BITS   = 256;     // one cache line
    localparam int BURST_BITS  = 64;      // one memory beat
    localparam int BEATS       = LINE_BITS / BURST_BITS;
    localparam int SETS        = 16;
    localparam int OFFSET_BITS = 5;       // byte within line
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = WORD_BITS - INDEX_BITS - OFFSET_BITS;

    typedef struct packed {
        logic [WORD_BITS-1:0]   addr;     // byte address
        logic                   read;
        logic                   write;
        logic [3:0]             wmask;    // byte lanes of wdata
        logic [WORD_BITS-1:0]   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [WORD_BITS-1:0]   rdata;
        logic                   resp;
    } cpu_rsp_t;

    typedef struct packed {
        logic [WORD_BITS-1:0]   addr;     // line aligned
        logic                   read;
        logic                   write;
        logic [LINE_BITS-1:0]   wdata;
    } line_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0]   rdata;
        logic                   resp;
    } line_rsp_t;

    typedef struct packed {
        logic [WORD_BITS-1:0]   addr;
        logic                   read;
        logic                   write;
        logic [BURST_BITS-1:0]  wdata;
    } bmem_req_t;

    typedef struct packed {
        logic [BURST_BITS-1:0]  rdata;
        logic                   resp;     // one per beat
    } bmem_rsp_t;

endpackage : mem_pkg

`default_nettype wire
